/* Bender.yml */
package:
  name: pattern_fetch_send

sources:
  - logic/pattern_pkg.sv
  - logic/pattern_word_fifo.sv
  - logic/pattern_sequencer.sv
  - logic/bit_serializer.sv
  - logic/pixel_output.sv
  - logic/pattern_fetch_send.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_pattern_fetch_send.sv

/* all.f */
+incdir+include
logic/pattern_pkg.sv
logic/pattern_word_fifo.sv
logic/pattern_sequencer.sv
logic/bit_serializer.sv
logic/pixel_output.sv
logic/pattern_fetch_send.sv
testbench/tb_pattern_fetch_send.sv

/* logic/bit_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_serializer
    import pattern_pkg::*;
#(
    parameter int WORD_BITS = 256,
    parameter int BITS_W    = $clog2(WORD_BITS + 1)
) (
    input  wire logic                 pixel_clk,
    input  wire logic                 pixel_rst_n,
    input  wire logic                 word_load,
    input  wire logic [WORD_BITS-1:0] body_word,
    input  wire logic [BITS_W-1:0]    body_bits,
    input  wire logic                 body_last,
    input  wire logic [FILL_W-1:0]    fill_factor,
    input  wire logic                 pixel_de,
    output logic                      word_room,
    output logic                      pat_bit,
    output logic                      bit_valid,
    output logic                      pattern_active
);

    // Active slot is shifted out, next slot waits behind it
    logic [WORD_BITS-1:0] act_word;
    logic [BITS_W-1:0]    act_bits;
    logic                 act_last;
    logic                 act_full;
    logic [WORD_BITS-1:0] nxt_word;
    logic [BITS_W-1:0]    nxt_bits;
    logic                 nxt_last;
    logic                 nxt_full;

    logic [BITS_W-1:0]    bit_idx;
    logic [FILL_W-1:0]    fill_cnt;

    logic consume;
    logic step_done;
    logic word_done;
    logic act_free;
    logic take_nxt;
    logic take_load;
    logic park_load;

    assign word_room = !nxt_full;
    assign bit_valid = pixel_de && act_full;
    assign pat_bit   = act_word[WORD_BITS - 1 - bit_idx];

    // A fill value of 0 or 1 gives one pixel per bit
    assign consume   = pixel_de && act_full;
    assign step_done = consume && (fill_factor <= FILL_W'(1) || fill_cnt == fill_factor - 1'b1);
    assign word_done = step_done && (bit_idx == act_bits - 1'b1);

    assign act_free  = !act_full || word_done;
    assign take_nxt  = act_free && nxt_full;
    assign take_load = act_free && !nxt_full && word_load;
    assign park_load = !act_free && word_load;

    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            act_full       <= 1'b0;
            nxt_full       <= 1'b0;
            bit_idx        <= '0;
            fill_cnt       <= '0;
            pattern_active <= 1'b0;
        end else begin
            if (word_done) begin
                bit_idx  <= '0;
                fill_cnt <= '0;
            end else if (step_done) begin
                bit_idx  <= bit_idx + 1'b1;
                fill_cnt <= '0;
            end else if (consume) begin
                fill_cnt <= fill_cnt + 1'b1;
            end

            if (take_nxt) begin
                act_full <= 1'b1;
                nxt_full <= 1'b0;
            end else if (take_load) begin
                act_full <= 1'b1;
            end else if (act_free) begin
                act_full <= 1'b0;
            end else if (park_load) begin
                nxt_full <= 1'b1;
            end

            // Stays up if another sequence is already queued
            if (word_done && act_last) begin
                pattern_active <= nxt_full || word_load;
            end else if (word_load) begin
                pattern_active <= 1'b1;
            end
        end
    end

    // Slot payload
    always_ff @(posedge pixel_clk) begin
        if (take_nxt) begin
            act_word <= nxt_word;
            act_bits <= nxt_bits;
            act_last <= nxt_last;
        end else if (take_load) begin
            act_word <= body_word;
            act_bits <= body_bits;
            act_last <= body_last;
        end
        if (park_load) begin
            nxt_word <= body_word;
            nxt_bits <= body_bits;
            nxt_last <= body_last;
        end
    end

    a_idx_in_word: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        act_full |-> (bit_idx < act_bits));

    // Sequencer only pops while the next slot is free
    a_load_with_room: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        word_load |-> word_room);

endmodule

`default_nettype wire

/* logic/pattern_fetch_send.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_fetch_send
    import pattern_pkg::*;
#(
    parameter int WORD_BITS  = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                 pixel_clk,
    input  wire logic                 pixel_rst_n,
    input  wire logic                 word_wr,
    input  wire logic [WORD_BITS-1:0] word_data,
    output logic                      word_full,
    input  wire logic                 pixel_de,
    input  wire logic                 pixel_hs,
    input  wire logic                 pixel_vs,
    output logic                      gen_de,
    output logic                      gen_hs,
    output logic                      gen_vs,
    output logic [COLOR_W-1:0]        gen_r,
    output logic [COLOR_W-1:0]        gen_g,
    output logic [COLOR_W-1:0]        gen_b,
    output logic                      pattern_active
);

    localparam int BITS_W = $clog2(WORD_BITS + 1);

    logic                 fifo_rd;
    logic                 fifo_empty;
    logic [WORD_BITS-1:0] fifo_rd_data;
    logic                 word_room;
    logic                 word_load;
    logic [WORD_BITS-1:0] body_word;
    logic [BITS_W-1:0]    body_bits;
    logic                 body_last;
    logic [FILL_W-1:0]    fill_factor;
    logic                 pat_bit;
    logic                 bit_valid;

    pattern_word_fifo #(
        .WORD_BITS  (WORD_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .pixel_clk    (pixel_clk),
        .pixel_rst_n  (pixel_rst_n),
        .word_wr      (word_wr),
        .word_data    (word_data),
        .fifo_rd      (fifo_rd),
        .word_full    (word_full),
        .fifo_empty   (fifo_empty),
        .fifo_rd_data (fifo_rd_data)
    );

    pattern_sequencer #(
        .WORD_BITS (WORD_BITS),
        .BITS_W    (BITS_W)
    ) i_sequencer (
        .pixel_clk    (pixel_clk),
        .pixel_rst_n  (pixel_rst_n),
        .fifo_empty   (fifo_empty),
        .fifo_rd_data (fifo_rd_data),
        .word_room    (word_room),
        .fifo_rd      (fifo_rd),
        .word_load    (word_load),
        .body_word    (body_word),
        .body_bits    (body_bits),
        .body_last    (body_last),
        .fill_factor  (fill_factor)
    );

    bit_serializer #(
        .WORD_BITS (WORD_BITS),
        .BITS_W    (BITS_W)
    ) i_serializer (
        .pixel_clk      (pixel_clk),
        .pixel_rst_n    (pixel_rst_n),
        .word_load      (word_load),
        .body_word      (body_word),
        .body_bits      (body_bits),
        .body_last      (body_last),
        .fill_factor    (fill_factor),
        .pixel_de       (pixel_de),
        .word_room      (word_room),
        .pat_bit        (pat_bit),
        .bit_valid      (bit_valid),
        .pattern_active (pattern_active)
    );

    pixel_output i_output (
        .pixel_clk   (pixel_clk),
        .pixel_rst_n (pixel_rst_n),
        .pixel_de    (pixel_de),
        .pixel_hs    (pixel_hs),
        .pixel_vs    (pixel_vs),
        .pat_bit     (pat_bit),
        .bit_valid   (bit_valid),
        .gen_de      (gen_de),
        .gen_hs      (gen_hs),
        .gen_vs      (gen_vs),
        .gen_r       (gen_r),
        .gen_g       (gen_g),
        .gen_b       (gen_b)
    );

endmodule

`default_nettype wire

/* logic/pattern_pkg.sv */
`default_nettype none

package pattern_pkg;

    // Header field widths
    localparam int TOTAL_BITS_W = 16;
    localparam int PAT_COUNT_W  = 8;
    localparam int FILL_W       = 8;

    // Distance of each field's MSB from the header word's MSB
    localparam int TOTAL_MSB_OFFSET = 0;
    localparam int COUNT_MSB_OFFSET = TOTAL_MSB_OFFSET + TOTAL_BITS_W;
    localparam int FILL_MSB_OFFSET  = COUNT_MSB_OFFSET + PAT_COUNT_W;

    // Video colour, one byte per channel
    localparam int COLOR_W = 8;
    localparam logic [3*COLOR_W-1:0] COLOR_BLACK = 24'h000000;
    localparam logic [3*COLOR_W-1:0] COLOR_WHITE = 24'hffffff;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        HEAD      = 3'd1,
        HEAD_WAIT = 3'd2,
        BODY      = 3'd3,
        BODY_WAIT = 3'd4
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/pattern_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_sequencer
    import pattern_pkg::*;
#(
    parameter int WORD_BITS = 256,
    parameter int BITS_W    = $clog2(WORD_BITS + 1)
) (
    input  wire logic                 pixel_clk,
    input  wire logic                 pixel_rst_n,
    input  wire logic                 fifo_empty,
    input  wire logic [WORD_BITS-1:0] fifo_rd_data,
    input  wire logic                 word_room,
    output logic                      fifo_rd,
    output logic                      word_load,
    output logic [WORD_BITS-1:0]      body_word,
    output logic [BITS_W-1:0]         body_bits,
    output logic                      body_last,
    output logic [FILL_W-1:0]         fill_factor
);

    seq_state_t              state;
    logic [TOTAL_BITS_W-1:0] words_per_pat;
    logic [TOTAL_BITS_W-1:0] word_cnt;
    logic [BITS_W-1:0]       tail_bits;
    logic [PAT_COUNT_W-1:0]  pat_left;
    logic                    last_word;

    // Header fields as seen on the FIFO output
    logic [TOTAL_BITS_W-1:0] hdr_total;
    logic [PAT_COUNT_W-1:0]  hdr_count;
    logic [FILL_W-1:0]       hdr_fill;

    assign hdr_total = fifo_rd_data[WORD_BITS-1-TOTAL_MSB_OFFSET -: TOTAL_BITS_W];
    assign hdr_count = fifo_rd_data[WORD_BITS-1-COUNT_MSB_OFFSET -: PAT_COUNT_W];
    assign hdr_fill  = fifo_rd_data[WORD_BITS-1-FILL_MSB_OFFSET -: FILL_W];

    assign last_word = (word_cnt == words_per_pat - 1'b1);

    // Pop the header once, body words only while the serializer has room
    assign fifo_rd   = (state == HEAD) || (state == BODY && word_room && !fifo_empty);
    assign word_load = (state == BODY_WAIT);
    assign body_word = fifo_rd_data;
    assign body_bits = (last_word && tail_bits != '0) ? tail_bits : BITS_W'(WORD_BITS);
    assign body_last = last_word && (pat_left == PAT_COUNT_W'(1));

    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            state         <= IDLE;
            words_per_pat <= '0;
            word_cnt      <= '0;
            tail_bits     <= '0;
            pat_left      <= '0;
            fill_factor   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!fifo_empty) begin
                        state <= HEAD;
                    end
                end
                HEAD: begin
                    state <= HEAD_WAIT;
                end
                HEAD_WAIT: begin
                    words_per_pat <= TOTAL_BITS_W'((32'(hdr_total) + WORD_BITS - 1) / WORD_BITS);
                    tail_bits     <= BITS_W'(32'(hdr_total) % WORD_BITS);
                    pat_left      <= hdr_count;
                    fill_factor   <= hdr_fill;
                    word_cnt      <= '0;
                    // An empty sequence has nothing to fetch
                    if (hdr_total == '0 || hdr_count == '0) begin
                        state <= IDLE;
                    end else begin
                        state <= BODY;
                    end
                end
                BODY: begin
                    if (word_room && !fifo_empty) begin
                        state <= BODY_WAIT;
                    end
                end
                BODY_WAIT: begin
                    if (!last_word) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= BODY;
                    end else if (pat_left == PAT_COUNT_W'(1)) begin
                        state <= IDLE;
                    end else begin
                        // Next pattern of the same header
                        pat_left <= pat_left - 1'b1;
                        word_cnt <= '0;
                        state    <= BODY;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_state_legal: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        state inside {IDLE, HEAD, HEAD_WAIT, BODY, BODY_WAIT});

endmodule

`default_nettype wire

/* logic/pattern_word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_word_fifo #(
    parameter int WORD_BITS  = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                 pixel_clk,
    input  wire logic                 pixel_rst_n,
    input  wire logic                 word_wr,
    input  wire logic [WORD_BITS-1:0] word_data,
    input  wire logic                 fifo_rd,
    output logic                      word_full,
    output logic                      fifo_empty,
    output logic [WORD_BITS-1:0]      fifo_rd_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WORD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic                 wr_en;
    logic                 rd_en;

    assign word_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign wr_en      = word_wr && !word_full;
    assign rd_en      = fifo_rd && !fifo_empty;

    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the level unchanged
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage and read register
    always_ff @(posedge pixel_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= word_data;
        end
        if (rd_en) begin
            fifo_rd_data <= mem[rd_ptr];
        end
    end

    // Writer has to honour the full level
    a_no_write_full: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        word_wr |-> !word_full);

    // Sequencer may only pop a non-empty FIFO
    a_no_read_empty: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        fifo_rd |-> !fifo_empty);

endmodule

`default_nettype wire

/* logic/pixel_output.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_output
    import pattern_pkg::*;
(
    input  wire logic          pixel_clk,
    input  wire logic          pixel_rst_n,
    input  wire logic          pixel_de,
    input  wire logic          pixel_hs,
    input  wire logic          pixel_vs,
    input  wire logic          pat_bit,
    input  wire logic          bit_valid,
    output logic               gen_de,
    output logic               gen_hs,
    output logic               gen_vs,
    output logic [COLOR_W-1:0] gen_r,
    output logic [COLOR_W-1:0] gen_g,
    output logic [COLOR_W-1:0] gen_b
);

    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            gen_de                <= 1'b0;
            gen_hs                <= 1'b1;
            gen_vs                <= 1'b1;
            {gen_r, gen_g, gen_b} <= '0;
        end else begin
            gen_de <= pixel_de;
            gen_hs <= pixel_hs;
            gen_vs <= pixel_vs;
            // Black only for a real 1 bit, white everywhere else
            if (bit_valid && pat_bit) begin
                {gen_r, gen_g, gen_b} <= COLOR_BLACK;
            end else begin
                {gen_r, gen_g, gen_b} <= COLOR_WHITE;
            end
        end
    end

endmodule

`default_nettype wire

/* include/tb_pattern_ref.svh */
`ifndef TB_PATTERN_REF_SVH
`define TB_PATTERN_REF_SVH

// Expected colour for each active pixel of one header and its body words
// Words are 32 bits wide; active pixels beyond the list are white
function automatic void tb_pattern_ref(
    input  logic [31:0] header,
    input  logic [31:0] body[$],
    output logic [23:0] exp_color[$]
);
    import pattern_pkg::*;
    int   total_bits;
    int   pat_count;
    int   fill;
    int   words_per_pat;
    int   word_idx;
    logic bit_val;

    total_bits    = header[31 - TOTAL_MSB_OFFSET -: TOTAL_BITS_W];
    pat_count     = header[31 - COUNT_MSB_OFFSET -: PAT_COUNT_W];
    fill          = header[31 - FILL_MSB_OFFSET -: FILL_W];
    fill          = (fill < 1) ? 1 : fill;
    words_per_pat = (total_bits + 31) / 32;
    exp_color.delete();

    // MSB first, every bit repeated fill times
    for (int p = 0; p < pat_count; p++) begin
        for (int i = 0; i < total_bits; i++) begin
            word_idx = p * words_per_pat + i / 32;
            bit_val  = (word_idx < body.size()) ? body[word_idx][31 - (i % 32)] : 1'b0;
            repeat (fill) begin
                exp_color.push_back(bit_val ? COLOR_BLACK : COLOR_WHITE);
            end
        end
    end
endfunction

`endif

/* testbench/tb_pattern_fetch_send.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pattern_fetch_send
    import pattern_pkg::*;
();

    localparam int FIFO_DEPTH = 16;
    localparam int DRIVE_DLY = 10;
    localparam int EXTRA_PIX = 16;
    localparam int SYNC_CYCLES = 64;
    // Active pixels of the four pattern tests plus the sync test
    localparam int PIXELS_TOTAL = SYNC_CYCLES + 75 + 40 * 3 + 20 * 2 * 2 + 18 * 32
                                  + 4 * EXTRA_PIX;
    localparam int TIMEOUT_CYCLES = 10 * PIXELS_TOTAL + 200;

    logic        pixel_clk;
    logic        pixel_rst_n;
    logic        word_wr;
    logic [31:0] word_data;
    logic        word_full;
    logic        pixel_de;
    logic        pixel_hs;
    logic        pixel_vs;
    logic        gen_de;
    logic        gen_hs;
    logic        gen_vs;
    logic [7:0]  gen_r;
    logic [7:0]  gen_g;
    logic [7:0]  gen_b;
    logic        pattern_active;

    integer      seed = 28;
    int          val_err = 0;
    int          misc_err = 0;
    int          cycle_cnt = 0;
    logic        check_en = 1'b0;
    logic        prev_de;
    logic        prev_hs;
    logic        prev_vs;
    logic [23:0] exp_col;
    logic [23:0] exp_q[$];

    `include "tb_pattern_ref.svh"

    pattern_fetch_send #(
        .WORD_BITS  (32),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .pixel_clk      (pixel_clk),
        .pixel_rst_n    (pixel_rst_n),
        .word_wr        (word_wr),
        .word_data      (word_data),
        .word_full      (word_full),
        .pixel_de       (pixel_de),
        .pixel_hs       (pixel_hs),
        .pixel_vs       (pixel_vs),
        .gen_de         (gen_de),
        .gen_hs         (gen_hs),
        .gen_vs         (gen_vs),
        .gen_r          (gen_r),
        .gen_g          (gen_g),
        .gen_b          (gen_b),
        .pattern_active (pattern_active)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #50 pixel_clk = ~pixel_clk;
    end

    task automatic drive_pixel(input logic de, input logic hs, input logic vs);
        @(posedge pixel_clk);
        #DRIVE_DLY;
        pixel_de = de;
        pixel_hs = hs;
        pixel_vs = vs;
    endtask

    task automatic write_word(input logic [31:0] w);
        @(posedge pixel_clk);
        #DRIVE_DLY;
        // Hold off while the FIFO reports full
        while (word_full) begin
            word_wr = 1'b0;
            @(posedge pixel_clk);
            #DRIVE_DLY;
        end
        word_wr   = 1'b1;
        word_data = w;
    endtask

    // Bursts of active pixels separated by random blanking gaps
    task automatic drive_active(input int n_pix);
        int left;
        int burst;
        int gap;
        left = n_pix;
        while (left > 0) begin
            burst = 1 + ($unsigned($random(seed)) % 8);
            if (burst > left) begin
                burst = left;
            end
            repeat (burst) drive_pixel(1'b1, 1'b1, 1'b1);
            left = left - burst;
            gap  = $unsigned($random(seed)) % 4;
            repeat (gap) drive_pixel(1'b0, 1'b1, 1'b1);
        end
        repeat (3) drive_pixel(1'b0, 1'b1, 1'b1);
    endtask

    task automatic run_pattern(input int total, input int count, input int fill,
                               input bit same_body);
        logic [31:0] hdr;
        logic [31:0] body_q[$];
        logic [23:0] ref_q[$];
        int          words_per_pat;
        logic        full_exp;
        hdr = '0;
        hdr[31 - TOTAL_MSB_OFFSET -: TOTAL_BITS_W] = TOTAL_BITS_W'(total);
        hdr[31 - COUNT_MSB_OFFSET -: PAT_COUNT_W]  = PAT_COUNT_W'(count);
        hdr[31 - FILL_MSB_OFFSET -: FILL_W]        = FILL_W'(fill);
        words_per_pat = (total + 31) / 32;
        for (int i = 0; i < words_per_pat * count; i++) begin
            if (same_body && i >= words_per_pat) begin
                body_q.push_back(body_q[i % words_per_pat]);
            end else begin
                body_q.push_back($random(seed));
            end
        end
        tb_pattern_ref(hdr, body_q, ref_q);
        write_word(hdr);
        foreach (body_q[i]) begin
            write_word(body_q[i]);
        end
        @(posedge pixel_clk);
        #DRIVE_DLY;
        word_wr = 1'b0;
        // Header and both serializer slots leave the FIFO while pixel_de is low
        full_exp = (body_q.size() + 1 >= FIFO_DEPTH + 3);
        assert (word_full === full_exp) else begin
            val_err++;
            $display("Fail word_full: got %h expected %h", word_full, full_exp);
        end
        while (!pattern_active) begin
            drive_pixel(1'b0, 1'b1, 1'b1);
        end
        foreach (ref_q[i]) begin
            exp_q.push_back(ref_q[i]);
        end
        // Extra pixels past the end must come out white
        drive_active(ref_q.size() + EXTRA_PIX);
        assert (exp_q.size() == 0) else begin
            misc_err++;
            $display("Not all expected pattern pixels reached the output (%0d left)",
                     exp_q.size());
            exp_q.delete();
        end
        assert (pattern_active == 1'b0) else begin
            val_err++;
            $display("Fail pattern_active: got %h expected %h", pattern_active, 1'b0);
        end
    endtask

    // Compare process, mid-cycle, against inputs of the cycle before
    always @(negedge pixel_clk) begin
        if (check_en) begin
            assert (gen_de === prev_de) else begin
                val_err++;
                $display("Fail gen_de: got %h expected %h at %0t", gen_de, prev_de, $time);
            end
            assert (gen_hs === prev_hs) else begin
                val_err++;
                $display("Fail gen_hs: got %h expected %h at %0t", gen_hs, prev_hs, $time);
            end
            assert (gen_vs === prev_vs) else begin
                val_err++;
                $display("Fail gen_vs: got %h expected %h at %0t", gen_vs, prev_vs, $time);
            end
            if (gen_de) begin
                if (exp_q.size() > 0) begin
                    exp_col = exp_q.pop_front();
                end else begin
                    exp_col = COLOR_WHITE;
                end
                assert ({gen_r, gen_g, gen_b} === exp_col) else begin
                    val_err++;
                    $display("Fail gen_rgb: got %h expected %h at %0t",
                             {gen_r, gen_g, gen_b}, exp_col, $time);
                end
            end
        end
        prev_de = pixel_de;
        prev_hs = pixel_hs;
        prev_vs = pixel_vs;
    end

    always @(posedge pixel_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d value, %0d other", val_err, misc_err + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        pixel_rst_n = 1'b0;
        word_wr     = 1'b0;
        word_data   = '0;
        pixel_de    = 1'b0;
        pixel_hs    = 1'b1;
        pixel_vs    = 1'b1;
        repeat (10) @(posedge pixel_clk);
        #DRIVE_DLY;
        assert ({gen_de, gen_hs, gen_vs, gen_r, gen_g, gen_b, pattern_active}
                === {3'b011, 24'h000000, 1'b0}) else begin
            val_err++;
            $display("Fail reset outputs: got %h expected %h",
                     {gen_de, gen_hs, gen_vs, gen_r, gen_g, gen_b, pattern_active},
                     {3'b011, 24'h000000, 1'b0});
        end
        pixel_rst_n = 1'b1;
        check_en    = 1'b1;

        // Random video timing with no pattern loaded
        repeat (SYNC_CYCLES) begin
            drive_pixel($random(seed), $random(seed), $random(seed));
        end
        repeat (3) drive_pixel(1'b0, 1'b1, 1'b1);
        assert (pattern_active == 1'b0) else begin
            val_err++;
            $display("Fail pattern_active: got %h expected %h", pattern_active, 1'b0);
        end

        run_pattern(75, 1, 1, 1'b0);
        run_pattern(40, 1, 3, 1'b0);
        run_pattern(20, 2, 2, 1'b1);
        // Enough body words to fill the FIFO before any pixel is drawn
        run_pattern(18 * 32, 1, 1, 1'b0);

        $display("Errors: %0d value, %0d other", val_err, misc_err);
        if (val_err == 0 && misc_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
